// ==== flight_controller.f ====
hdl/flight_pkg.sv
hdl/us_tick.sv
hdl/pulse_width_decoder.sv
hdl/angle_controller.sv
hdl/body_rate_controller.sv
hdl/motor_mixer.sv
hdl/esc_pulse_generator.sv
hdl/flight_controller.sv
test/flight_controller_tb.sv

// ==== hdl/angle_controller.sv ====
// ************************************************
// Angle controller
// Stick offsets minus IMU angles give target rates
// ************************************************
`default_nettype none

module angle_controller (
    input  logic                                    sys_clk,
    input  logic                                    resetn,
    input  logic                                    start,
    input  logic [flight_pkg::REC_VAL_W-1:0]        throttle_val,
    input  logic [flight_pkg::REC_VAL_W-1:0]        roll_val,
    input  logic [flight_pkg::REC_VAL_W-1:0]        pitch_val,
    input  logic [flight_pkg::REC_VAL_W-1:0]        yaw_val,
    input  logic signed [flight_pkg::RATE_W-1:0]    roll_angle,
    input  logic signed [flight_pkg::RATE_W-1:0]    pitch_angle,
    output logic signed [flight_pkg::RATE_W-1:0]    throttle_rate,
    output logic signed [flight_pkg::RATE_W-1:0]    roll_target,
    output logic signed [flight_pkg::RATE_W-1:0]    pitch_target,
    output logic signed [flight_pkg::RATE_W-1:0]    yaw_target,
    output logic                                    done
);

    localparam int W = flight_pkg::RATE_W;

    logic signed [W-1:0] roll_stick;
    logic signed [W-1:0] pitch_stick;
    logic signed [W-1:0] yaw_stick;

    // Stick values relative to center
    assign roll_stick  = $signed(W'(roll_val)) - W'(flight_pkg::STICK_CENTER);
    assign pitch_stick = $signed(W'(pitch_val)) - W'(flight_pkg::STICK_CENTER);
    assign yaw_stick   = $signed(W'(yaw_val)) - W'(flight_pkg::STICK_CENTER);

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    // Target registers, loaded per IMU sample
    always_ff @(posedge sys_clk) begin
        if (start) begin
            throttle_rate <= $signed(W'(throttle_val));
            roll_target   <= roll_stick - roll_angle;
            pitch_target  <= pitch_stick - pitch_angle;
            // No yaw angle loop, stick sets rate
            yaw_target    <= yaw_stick;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/body_rate_controller.sv ====
// ************************************************
// Body rate controller
// Proportional rate loop with saturated axis commands
// ************************************************
`default_nettype none

module body_rate_controller (
    input  logic                                    sys_clk,
    input  logic                                    resetn,
    input  logic                                    start,
    input  logic signed [flight_pkg::RATE_W-1:0]    roll_target,
    input  logic signed [flight_pkg::RATE_W-1:0]    pitch_target,
    input  logic signed [flight_pkg::RATE_W-1:0]    yaw_target,
    input  logic signed [flight_pkg::RATE_W-1:0]    roll_gyro,
    input  logic signed [flight_pkg::RATE_W-1:0]    pitch_gyro,
    input  logic signed [flight_pkg::RATE_W-1:0]    yaw_gyro,
    output logic signed [flight_pkg::RATE_W-1:0]    roll_cmd,
    output logic signed [flight_pkg::RATE_W-1:0]    pitch_cmd,
    output logic signed [flight_pkg::RATE_W-1:0]    yaw_cmd,
    output logic                                    done
);

    localparam int W = flight_pkg::RATE_W;

    // Error at one extra bit, gain of one half, then saturate
    function automatic logic signed [W-1:0] rate_cmd(
        input logic signed [W-1:0] target,
        input logic signed [W-1:0] gyro
    );
        logic signed [W:0] err;
        logic signed [W:0] scaled;
        err    = target - gyro;
        scaled = err >>> 1;
        if (scaled > (W + 1)'(flight_pkg::CMD_LIMIT)) begin
            return W'(flight_pkg::CMD_LIMIT);
        end else if (scaled < -(W + 1)'(flight_pkg::CMD_LIMIT)) begin
            return -W'(flight_pkg::CMD_LIMIT);
        end
        return scaled[W-1:0];
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (start) begin
            roll_cmd  <= rate_cmd(roll_target, roll_gyro);
            pitch_cmd <= rate_cmd(pitch_target, pitch_gyro);
            yaw_cmd   <= rate_cmd(yaw_target, yaw_gyro);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/esc_pulse_generator.sv ====
// ************************************************
// ESC pulse generator
// Four outputs, 1000 + 4 * rate us per fixed frame
// ************************************************
`default_nettype none

module esc_pulse_generator #(
    parameter int ESC_FRAME_US = 2500
) (
    input  logic                            sys_clk,
    input  logic                            resetn,
    input  logic                            us_pulse,
    input  logic [flight_pkg::REC_VAL_W-1:0] motor_1_rate,
    input  logic [flight_pkg::REC_VAL_W-1:0] motor_2_rate,
    input  logic [flight_pkg::REC_VAL_W-1:0] motor_3_rate,
    input  logic [flight_pkg::REC_VAL_W-1:0] motor_4_rate,
    output logic                            motor_1_pwm,
    output logic                            motor_2_pwm,
    output logic                            motor_3_pwm,
    output logic                            motor_4_pwm
);

    localparam int FRAME_W = $clog2(ESC_FRAME_US);

    logic [flight_pkg::REC_VAL_W-1:0] rate [4];
    logic [FRAME_W-1:0]               high_us [4];
    logic [FRAME_W-1:0]               frame_us;
    logic [3:0]                       pwm;
    logic                             frame_start;

    assign rate[0] = motor_1_rate;
    assign rate[1] = motor_2_rate;
    assign rate[2] = motor_3_rate;
    assign rate[3] = motor_4_rate;

    assign motor_1_pwm = pwm[0];
    assign motor_2_pwm = pwm[1];
    assign motor_3_pwm = pwm[2];
    assign motor_4_pwm = pwm[3];

    assign frame_start = (frame_us == '0);

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            frame_us <= '0;
            pwm      <= '0;
        end else if (us_pulse) begin
            frame_us <= (frame_us == FRAME_W'(ESC_FRAME_US - 1)) ? '0 : frame_us + 1'b1;
            // High from frame start until the latched width
            for (int i = 0; i < 4; i++) begin
                pwm[i] <= frame_start || (frame_us < high_us[i]);
            end
        end
    end

    // Widths sampled once per frame
    always_ff @(posedge sys_clk) begin
        if (us_pulse && frame_start) begin
            for (int i = 0; i < 4; i++) begin
                high_us[i] <= FRAME_W'(flight_pkg::PULSE_MIN_US)
                            + FRAME_W'(rate[i]) * FRAME_W'(flight_pkg::US_PER_STEP);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/flight_controller.sv ====
// ************************************************
// Flight controller top level
// Receiver decoders, arming, control chain, ESC outputs
// ************************************************
`default_nettype none

module flight_controller #(
    parameter int CLKS_PER_US  = 38,
    parameter int ESC_FRAME_US = 2500
) (
    input  logic                                    sys_clk,
    input  logic                                    resetn,
    input  logic                                    throttle_pwm,
    input  logic                                    yaw_pwm,
    input  logic                                    roll_pwm,
    input  logic                                    pitch_pwm,
    input  logic                                    mode_pwm,
    input  logic                                    imu_valid,
    input  logic signed [flight_pkg::RATE_W-1:0]    roll_angle,
    input  logic signed [flight_pkg::RATE_W-1:0]    pitch_angle,
    input  logic signed [flight_pkg::RATE_W-1:0]    roll_gyro,
    input  logic signed [flight_pkg::RATE_W-1:0]    pitch_gyro,
    input  logic signed [flight_pkg::RATE_W-1:0]    yaw_gyro,
    output logic                                    motor_1_pwm,
    output logic                                    motor_2_pwm,
    output logic                                    motor_3_pwm,
    output logic                                    motor_4_pwm,
    output logic                                    armed
);

    localparam int VAL_W  = flight_pkg::REC_VAL_W;
    localparam int RATE_W = flight_pkg::RATE_W;
    // Throttle must be near idle to arm
    localparam int ARM_THROTTLE_MAX = 10;

    logic                     us_pulse;
    logic [VAL_W-1:0]         throttle_val;
    logic [VAL_W-1:0]         yaw_val;
    logic [VAL_W-1:0]         roll_val;
    logic [VAL_W-1:0]         pitch_val;
    logic [VAL_W-1:0]         mode_val;
    logic signed [RATE_W-1:0] throttle_rate;
    logic signed [RATE_W-1:0] roll_target;
    logic signed [RATE_W-1:0] pitch_target;
    logic signed [RATE_W-1:0] yaw_target;
    logic signed [RATE_W-1:0] roll_cmd;
    logic signed [RATE_W-1:0] pitch_cmd;
    logic signed [RATE_W-1:0] yaw_cmd;
    logic                     ac_done;
    logic                     brc_done;
    logic [VAL_W-1:0]         motor_1_rate;
    logic [VAL_W-1:0]         motor_2_rate;
    logic [VAL_W-1:0]         motor_3_rate;
    logic [VAL_W-1:0]         motor_4_rate;

    us_tick #(.CLKS_PER_US(CLKS_PER_US)) u_us_tick (
        .sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse)
    );

    // One decoder per receiver channel
    pulse_width_decoder u_dec_throttle (
        .sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse),
        .pwm_in(throttle_pwm), .value(throttle_val)
    );
    pulse_width_decoder u_dec_yaw (
        .sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse),
        .pwm_in(yaw_pwm), .value(yaw_val)
    );
    pulse_width_decoder u_dec_roll (
        .sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse),
        .pwm_in(roll_pwm), .value(roll_val)
    );
    pulse_width_decoder u_dec_pitch (
        .sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse),
        .pwm_in(pitch_pwm), .value(pitch_val)
    );
    pulse_width_decoder u_dec_mode (
        .sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse),
        .pwm_in(mode_pwm), .value(mode_val)
    );

    // Arm only from low throttle, disarm on switch alone
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            armed <= 1'b0;
        end else if (!armed) begin
            armed <= (mode_val > VAL_W'(flight_pkg::ARM_LEVEL))
                  && (throttle_val < VAL_W'(ARM_THROTTLE_MAX));
        end else if (mode_val <= VAL_W'(flight_pkg::ARM_LEVEL)) begin
            armed <= 1'b0;
        end
    end

    // Control chain, one stage per cycle after imu_valid
    angle_controller u_angle (
        .sys_clk(sys_clk), .resetn(resetn), .start(imu_valid),
        .throttle_val(throttle_val), .roll_val(roll_val),
        .pitch_val(pitch_val), .yaw_val(yaw_val),
        .roll_angle(roll_angle), .pitch_angle(pitch_angle),
        .throttle_rate(throttle_rate), .roll_target(roll_target),
        .pitch_target(pitch_target), .yaw_target(yaw_target),
        .done(ac_done)
    );

    body_rate_controller u_body_rate (
        .sys_clk(sys_clk), .resetn(resetn), .start(ac_done),
        .roll_target(roll_target), .pitch_target(pitch_target),
        .yaw_target(yaw_target), .roll_gyro(roll_gyro),
        .pitch_gyro(pitch_gyro), .yaw_gyro(yaw_gyro),
        .roll_cmd(roll_cmd), .pitch_cmd(pitch_cmd), .yaw_cmd(yaw_cmd),
        .done(brc_done)
    );

    motor_mixer u_mixer (
        .sys_clk(sys_clk), .resetn(resetn), .start(brc_done), .armed(armed),
        .throttle_rate(throttle_rate), .roll_cmd(roll_cmd),
        .pitch_cmd(pitch_cmd), .yaw_cmd(yaw_cmd),
        .motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
        .motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate)
    );

    esc_pulse_generator #(.ESC_FRAME_US(ESC_FRAME_US)) u_esc (
        .sys_clk(sys_clk), .resetn(resetn), .us_pulse(us_pulse),
        .motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
        .motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate),
        .motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
        .motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm)
    );

endmodule

`default_nettype wire

// ==== hdl/flight_pkg.sv ====
// ************************************************
// Shared flight datapath definitions
// Value widths, stick and pulse constants
// Motor mixer and arming limits
// ************************************************
`default_nettype none

package flight_pkg;

    // Decoded receiver and motor rate width
    localparam int REC_VAL_W = 8;
    // Signed angle, rate and command width
    localparam int RATE_W = 16;

    // Neutral stick position on the 0..250 scale
    localparam int STICK_CENTER = 125;
    // Top of motor and receiver scale
    localparam int MOTOR_RATE_MAX = 250;
    // Axis command magnitude limit
    localparam int CMD_LIMIT = 125;
    // Mode switch must exceed this to arm
    localparam int ARM_LEVEL = 125;

    // Pulse width for value 0, receiver and ESC
    localparam int PULSE_MIN_US = 1000;
    // Receiver pulse width for value 250
    localparam int PULSE_MAX_US = 2000;
    // One value step in microseconds
    localparam int US_PER_STEP = 4;

endpackage

`default_nettype wire

// ==== hdl/motor_mixer.sv ====
// ************************************************
// Quad-X motor mixer
// Arming gate and clamp to 0..250 motor rates
// ************************************************
`default_nettype none

module motor_mixer (
    input  logic                                    sys_clk,
    input  logic                                    resetn,
    input  logic                                    start,
    input  logic                                    armed,
    input  logic signed [flight_pkg::RATE_W-1:0]    throttle_rate,
    input  logic signed [flight_pkg::RATE_W-1:0]    roll_cmd,
    input  logic signed [flight_pkg::RATE_W-1:0]    pitch_cmd,
    input  logic signed [flight_pkg::RATE_W-1:0]    yaw_cmd,
    output logic [flight_pkg::REC_VAL_W-1:0]        motor_1_rate,
    output logic [flight_pkg::REC_VAL_W-1:0]        motor_2_rate,
    output logic [flight_pkg::REC_VAL_W-1:0]        motor_3_rate,
    output logic [flight_pkg::REC_VAL_W-1:0]        motor_4_rate
);

    localparam int SUM_W = flight_pkg::RATE_W + 2;
    localparam int VAL_W = flight_pkg::REC_VAL_W;

    logic signed [SUM_W-1:0] m1_sum;
    logic signed [SUM_W-1:0] m2_sum;
    logic signed [SUM_W-1:0] m3_sum;
    logic signed [SUM_W-1:0] m4_sum;

    function automatic logic [VAL_W-1:0] clamp_rate(input logic signed [SUM_W-1:0] s);
        if (s < 0) begin
            return '0;
        end else if (s > SUM_W'(flight_pkg::MOTOR_RATE_MAX)) begin
            return VAL_W'(flight_pkg::MOTOR_RATE_MAX);
        end
        return s[VAL_W-1:0];
    endfunction

    // Quad-X sums, widened so no term overflows
    assign m1_sum = throttle_rate + roll_cmd + pitch_cmd - yaw_cmd;
    assign m2_sum = throttle_rate - roll_cmd + pitch_cmd + yaw_cmd;
    assign m3_sum = throttle_rate - roll_cmd - pitch_cmd - yaw_cmd;
    assign m4_sum = throttle_rate + roll_cmd - pitch_cmd + yaw_cmd;

    always_ff @(posedge sys_clk) begin
        // Disarm forces motors to idle at once
        if (!resetn || !armed) begin
            motor_1_rate <= '0;
            motor_2_rate <= '0;
            motor_3_rate <= '0;
            motor_4_rate <= '0;
        end else if (start) begin
            motor_1_rate <= clamp_rate(m1_sum);
            motor_2_rate <= clamp_rate(m2_sum);
            motor_3_rate <= clamp_rate(m3_sum);
            motor_4_rate <= clamp_rate(m4_sum);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pulse_width_decoder.sv ====
// ************************************************
// Receiver channel decoder
// Measures high time in microseconds, maps to 0..250
// ************************************************
`default_nettype none

module pulse_width_decoder (
    input  logic                                sys_clk,
    input  logic                                resetn,
    input  logic                                us_pulse,
    input  logic                                pwm_in,
    output logic [flight_pkg::REC_VAL_W-1:0]    value
);

    localparam int VAL_W   = flight_pkg::REC_VAL_W;
    localparam int CNT_W   = 12;
    localparam int MIN_US  = flight_pkg::PULSE_MIN_US;
    localparam int MAX_US  = flight_pkg::PULSE_MAX_US;

    logic [1:0]       sync;
    logic             pwm_prev;
    logic             rise;
    logic             fall;
    logic [CNT_W-1:0] high_us;
    logic [CNT_W-1:0] excess_us;

    // Edges seen on the synchronized level
    assign rise = sync[1] & ~pwm_prev;
    assign fall = ~sync[1] & pwm_prev;

    // Offset and clamp to the 1000 us span
    always_comb begin
        if (high_us < CNT_W'(MIN_US)) begin
            excess_us = '0;
        end else if (high_us > CNT_W'(MAX_US)) begin
            excess_us = CNT_W'(MAX_US - MIN_US);
        end else begin
            excess_us = high_us - CNT_W'(MIN_US);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            sync     <= '0;
            pwm_prev <= 1'b0;
            high_us  <= '0;
            value    <= '0;
        end else begin
            // Two-flop synchronizer
            sync     <= {sync[0], pwm_in};
            pwm_prev <= sync[1];
            // Restart on rising edge, tick may land in the same cycle
            if (rise) begin
                high_us <= us_pulse ? CNT_W'(1) : '0;
            end else if (sync[1] && us_pulse && high_us != '1) begin
                high_us <= high_us + 1'b1;
            end
            // New value at end of pulse
            if (fall) begin
                value <= VAL_W'(excess_us / CNT_W'(flight_pkg::US_PER_STEP));
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/us_tick.sv ====
// ************************************************
// Microsecond tick divider from sys_clk
// ************************************************
`default_nettype none

module us_tick #(
    parameter int CLKS_PER_US = 38
) (
    input  logic sys_clk,
    input  logic resetn,
    output logic us_pulse
);

    localparam int CNT_W = (CLKS_PER_US > 1) ? $clog2(CLKS_PER_US) : 1;

    logic [CNT_W-1:0] clk_cnt;
    logic             wrap;

    // Last cycle of each microsecond
    assign wrap = (clk_cnt == CNT_W'(CLKS_PER_US - 1));

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            clk_cnt  <= '0;
            us_pulse <= 1'b0;
        end else begin
            us_pulse <= wrap;
            clk_cnt  <= wrap ? '0 : clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the flight controller testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the run fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module flight_controller_tb \
    -f flight_controller.f \
    -o flight_controller_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/flight_controller_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi
exit 0

// ==== test/flight_controller_tb.sv ====
// ************************************************
// Flight controller testbench
// Receiver pulse and IMU models, ESC width monitor
// Directed tests for arming, throttle, mixing, feedback
// ************************************************
`default_nettype none

module flight_controller_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLKS_PER_US  = 2;
    localparam int ESC_FRAME_US = 2500;
    // Receiver frame repeats every 3000 us
    localparam int RX_PERIOD_US = 3000;
    localparam int FRAME_CYCLES = CLKS_PER_US * ESC_FRAME_US;
    // About a dozen ESC frames for each of five tests
    localparam int TIMEOUT_CYCLES = 5 * 12 * FRAME_CYCLES;

    logic sys_clk;
    logic resetn;
    logic throttle_pwm;
    logic yaw_pwm;
    logic roll_pwm;
    logic pitch_pwm;
    logic mode_pwm;
    logic imu_valid;
    logic signed [15:0] roll_angle;
    logic signed [15:0] pitch_angle;
    logic signed [15:0] roll_gyro;
    logic signed [15:0] pitch_gyro;
    logic signed [15:0] yaw_gyro;
    logic motor_1_pwm;
    logic motor_2_pwm;
    logic motor_3_pwm;
    logic motor_4_pwm;
    logic armed;

    // Receiver widths in us picked up at each frame start
    int thr_us = 1000;
    int yaw_us = 1500;
    int roll_us = 1500;
    int pitch_us = 1500;
    int mode_us = 1000;
    int rx_frames = 0;
    int cycle_count = 0;
    int seed = 24683;
    int meas_us [4];
    int exp_rate [4];

    flight_controller #(.CLKS_PER_US(CLKS_PER_US), .ESC_FRAME_US(ESC_FRAME_US)) uut (
        .sys_clk(sys_clk), .resetn(resetn),
        .throttle_pwm(throttle_pwm), .yaw_pwm(yaw_pwm), .roll_pwm(roll_pwm),
        .pitch_pwm(pitch_pwm), .mode_pwm(mode_pwm), .imu_valid(imu_valid),
        .roll_angle(roll_angle), .pitch_angle(pitch_angle), .roll_gyro(roll_gyro),
        .pitch_gyro(pitch_gyro), .yaw_gyro(yaw_gyro),
        .motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
        .motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm), .armed(armed)
    );

    initial sys_clk = 1'b0;
    always #50 sys_clk = ~sys_clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES));
        end
    end

    // Expected decoder value for a high time in us
    function automatic int stick_value(input int w_us);
        int excess;
        excess = w_us - 1000;
        if (excess < 0) excess = 0;
        if (excess > 1000) excess = 1000;
        return excess / 4;
    endfunction

    // Half of the rate error limited to +-125
    function automatic int axis_cmd(input int target, input int gyro);
        int cmd;
        cmd = (target - gyro) >>> 1;
        if (cmd > 125) cmd = 125;
        if (cmd < -125) cmd = -125;
        return cmd;
    endfunction

    function automatic int motor_clamp(input int sum);
        return (sum < 0) ? 0 : ((sum > 250) ? 250 : sum);
    endfunction

    // One receiver frame with all channels rising together
    task automatic drive_rx_frame(input int t_us, y_us, r_us, p_us, m_us);
        for (int c = 0; c < RX_PERIOD_US * CLKS_PER_US; c++) begin
            @(posedge sys_clk);
            #1;
            throttle_pwm = (c < t_us * CLKS_PER_US);
            yaw_pwm      = (c < y_us * CLKS_PER_US);
            roll_pwm     = (c < r_us * CLKS_PER_US);
            pitch_pwm    = (c < p_us * CLKS_PER_US);
            mode_pwm     = (c < m_us * CLKS_PER_US);
        end
    endtask

    initial begin
        @(posedge resetn);
        forever begin
            drive_rx_frame(thr_us, yaw_us, roll_us, pitch_us, mode_us);
            rx_frames = rx_frames + 1;
        end
    end

    task automatic wait_rx_frames(input int n);
        int target;
        target = rx_frames + n;
        while (rx_frames < target) @(negedge sys_clk);
    endtask

    // IMU sample strobe with angles and rates held afterwards
    task automatic pulse_imu(input int ra, pa, rg, pg, yg);
        @(posedge sys_clk);
        #1;
        roll_angle  = 16'(ra);
        pitch_angle = 16'(pa);
        roll_gyro   = 16'(rg);
        pitch_gyro  = 16'(pg);
        yaw_gyro    = 16'(yg);
        imu_valid   = 1'b1;
        @(posedge sys_clk);
        #1;
        imu_valid = 1'b0;
    endtask

    // High time of all four motors in one full frame
    task automatic measure_widths();
        int cnt [4];
        logic [3:0] pwm;
        for (int i = 0; i < 4; i++) cnt[i] = 0;
        @(negedge sys_clk);
        while (motor_1_pwm) @(negedge sys_clk);
        while (!motor_1_pwm) @(negedge sys_clk);
        pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
        while (pwm != 4'b0) begin
            for (int i = 0; i < 4; i++) cnt[i] = cnt[i] + int'(pwm[i]);
            @(negedge sys_clk);
            pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
        end
        for (int i = 0; i < 4; i++) meas_us[i] = cnt[i] / CLKS_PER_US;
    endtask

    task automatic verify_armed(input bit exp);
        @(negedge sys_clk);
        assert (armed == exp)
        else stop_on_error($sformatf("** Error: armed is 0x%0h, expected 0x%0h", armed, exp));
    endtask

    task automatic check_motor_widths();
        measure_widths();
        for (int i = 0; i < 4; i++) begin
            assert (meas_us[i] == 1000 + 4 * exp_rate[i])
            else stop_on_error($sformatf("** Error: motor_%0d_pwm width 0x%0h us, expected 0x%0h",
                i + 1, meas_us[i], 1000 + 4 * exp_rate[i]));
        end
    endtask

    // Set sticks, send one IMU sample, compare all ESC widths
    task automatic fly_and_check(input int t_us, r_us, p_us, y_us,
                                 input int ra, pa, rg, pg, yg, input bit exp_armed);
        int t;
        int rc;
        int pc;
        int yc;
        thr_us   = t_us;
        roll_us  = r_us;
        pitch_us = p_us;
        yaw_us   = y_us;
        wait_rx_frames(2);
        pulse_imu(ra, pa, rg, pg, yg);
        // Three chain stages plus margin
        repeat (4) @(posedge sys_clk);
        t  = stick_value(t_us);
        rc = axis_cmd(stick_value(r_us) - 125 - ra, rg);
        pc = axis_cmd(stick_value(p_us) - 125 - pa, pg);
        yc = axis_cmd(stick_value(y_us) - 125, yg);
        exp_rate[0] = exp_armed ? motor_clamp(t + rc + pc - yc) : 0;
        exp_rate[1] = exp_armed ? motor_clamp(t - rc + pc + yc) : 0;
        exp_rate[2] = exp_armed ? motor_clamp(t - rc - pc - yc) : 0;
        exp_rate[3] = exp_armed ? motor_clamp(t + rc - pc + yc) : 0;
        verify_armed(exp_armed);
        check_motor_widths();
    endtask

    task automatic idle_after_reset();
        verify_armed(1'b0);
        for (int i = 0; i < 4; i++) exp_rate[i] = 0;
        check_motor_widths();
    endtask

    task automatic arm_and_disarm();
        mode_us = 1800;
        wait_rx_frames(2);
        verify_armed(1'b1);
        fly_and_check(1000, 1500, 1500, 1500, 0, 0, 0, 0, 0, 1'b1);
        mode_us = 1100;
        wait_rx_frames(2);
        verify_armed(1'b0);
        // Switch raised with throttle up must not arm
        thr_us = 1600;
        wait_rx_frames(2);
        mode_us = 1800;
        wait_rx_frames(2);
        verify_armed(1'b0);
        // Throttle up while disarmed keeps motors idle
        fly_and_check(1600, 1500, 1500, 1500, 0, 0, 0, 0, 0, 1'b0);
    endtask

    task automatic throttle_mapping();
        int w;
        thr_us = 1000;
        wait_rx_frames(2);
        verify_armed(1'b1);
        // Below range, in range, above range
        w = 850 + int'($unsigned($random(seed)) % 150);
        fly_and_check(w, 1500, 1500, 1500, 0, 0, 0, 0, 0, 1'b1);
        w = 1000 + int'($unsigned($random(seed)) % 1001);
        fly_and_check(w, 1500, 1500, 1500, 0, 0, 0, 0, 0, 1'b1);
        w = 2001 + int'($unsigned($random(seed)) % 150);
        fly_and_check(w, 1500, 1500, 1500, 0, 0, 0, 0, 0, 1'b1);
    endtask

    task automatic mixing_signs();
        int r;
        int p;
        int y;
        for (int n = 0; n < 2; n++) begin
            r = 1000 + int'($unsigned($random(seed)) % 1001);
            p = 1000 + int'($unsigned($random(seed)) % 1001);
            y = 1000 + int'($unsigned($random(seed)) % 1001);
            fly_and_check(1500, r, p, y, 0, 0, 0, 0, 0, 1'b1);
        end
    endtask

    task automatic imu_feedback();
        // Odd negative error checks the arithmetic shift
        fly_and_check(1500, 1500, 1500, 1500, 21, -14, 10, 30, -16, 1'b1);
        // Saturated commands drive motors to both ends
        fly_and_check(1200, 1500, 1000, 1000, -1000, 0, 0, -1000, 1000, 1'b1);
    endtask

    initial begin
        resetn       = 1'b0;
        throttle_pwm = 1'b0;
        yaw_pwm      = 1'b0;
        roll_pwm     = 1'b0;
        pitch_pwm    = 1'b0;
        mode_pwm     = 1'b0;
        imu_valid    = 1'b0;
        roll_angle   = '0;
        pitch_angle  = '0;
        roll_gyro    = '0;
        pitch_gyro   = '0;
        yaw_gyro     = '0;
        repeat (10) @(posedge sys_clk);
        #1;
        resetn = 1'b1;
        idle_after_reset();
        arm_and_disarm();
        throttle_mapping();
        mixing_signs();
        imu_feedback();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
